// File: design/kbd_defs.svh
`ifndef KBD_DEFS_SVH
`define KBD_DEFS_SVH

// Number of entries in the scan code FIFO.
`define KBD_FIFO_DEPTH 8

// Address bits for the FIFO storage.
`define KBD_FIFO_AW 3

// Flops in each PS/2 line synchronizer.
`define PS2_SYNC_STAGES 3

// clk cycles without a PS/2 falling edge before a partial frame is dropped.
`define PS2_FRAME_TIMEOUT 2000

// All segments off on an active-low display.
`define SEG_BLANK 7'b1111111

`endif

// File: design/kbd_pkg.sv
package kbd_pkg;

    // One PS/2 scan code byte.
    typedef logic [7:0] scan_code_t;

    // Active-low segments, a in the high bit down to g in bit 0.
    typedef logic [6:0] seg_t;

    // Position inside an 11-bit PS/2 frame.
    typedef enum logic [1:0] {
        RX_IDLE,   // Waiting for a start bit.
        RX_DATA,   // Shifting in the eight data bits.
        RX_PARITY, // Expecting the odd parity bit.
        RX_STOP    // Expecting the stop bit.
    } rx_state_t;

endpackage

// File: design/ps2_frame_rx.sv
`timescale 1ns/1ps
`include "kbd_defs.svh"

module ps2_frame_rx (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ps2_clk,
    input  logic               ps2_data,
    output kbd_pkg::scan_code_t rx_code,
    output logic               rx_valid,
    output logic               rx_error
);
    import kbd_pkg::*;

    localparam int unsigned WD_W   = $clog2(`PS2_FRAME_TIMEOUT);
    localparam int unsigned WD_MAX = `PS2_FRAME_TIMEOUT - 1;

    logic [`PS2_SYNC_STAGES-1:0] clk_sync;
    logic [`PS2_SYNC_STAGES-1:0] data_sync;
    logic                        clk_prev;
    logic                        ps2_fall;
    logic                        data_bit;
    rx_state_t                   state;
    logic [2:0]                  bit_cnt;
    logic                        parity_ok;
    scan_code_t                  shift_reg;
    logic [WD_W-1:0]             wd_cnt;
    logic                        wd_expired;

    // Both lines idle high, so the chains start at ones.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clk_sync  <= '1;
            data_sync <= '1;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[`PS2_SYNC_STAGES-2:0], ps2_clk};
            data_sync <= {data_sync[`PS2_SYNC_STAGES-2:0], ps2_data};
            clk_prev  <= clk_sync[`PS2_SYNC_STAGES-1];
        end
    end

    assign ps2_fall = clk_prev & ~clk_sync[`PS2_SYNC_STAGES-1];
    assign data_bit = data_sync[`PS2_SYNC_STAGES-1];

    assign wd_expired = (state != RX_IDLE) && !ps2_fall && (wd_cnt == WD_W'(WD_MAX));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= RX_IDLE;
            bit_cnt   <= 3'd0;
            parity_ok <= 1'b0;
            wd_cnt    <= '0;
            rx_valid  <= 1'b0;
            rx_error  <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            rx_error <= 1'b0;
            if (state == RX_IDLE || ps2_fall) begin
                wd_cnt <= '0;
            end else begin
                wd_cnt <= wd_cnt + 1'b1;
            end
            if (wd_expired) begin
                state    <= RX_IDLE; // Clock stalled mid-frame.
                rx_error <= 1'b1;
            end else if (ps2_fall) begin
                case (state)
                    RX_IDLE: begin
                        if (!data_bit) begin
                            state   <= RX_DATA;
                            bit_cnt <= 3'd0;
                        end
                    end
                    RX_DATA: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_PARITY;
                        end
                    end
                    RX_PARITY: begin
                        parity_ok <= ^{shift_reg, data_bit}; // Odd parity gives a one.
                        state     <= RX_STOP;
                    end
                    RX_STOP: begin
                        rx_valid <= parity_ok & data_bit;
                        rx_error <= ~(parity_ok & data_bit);
                        state    <= RX_IDLE;
                    end
                    default: state <= RX_IDLE;
                endcase
            end
        end
    end

    // Data arrives LSB first.
    always_ff @(posedge clk) begin
        if (ps2_fall && state == RX_DATA) begin
            shift_reg <= {data_bit, shift_reg[7:1]};
        end
        if (ps2_fall && state == RX_STOP) begin
            rx_code <= shift_reg;
        end
    end

endmodule

// File: design/scan_fifo.sv
`timescale 1ns/1ps
`include "kbd_defs.svh"

module scan_fifo (
    input  logic                clk,
    input  logic                rst_n,
    input  kbd_pkg::scan_code_t rx_code,
    input  logic                rx_valid,
    output kbd_pkg::scan_code_t code,
    output logic                code_valid,
    input  logic                code_ready,
    output logic                overflow
);
    import kbd_pkg::*;

    scan_code_t             mem [`KBD_FIFO_DEPTH];
    logic [`KBD_FIFO_AW:0]  wr_ptr;
    logic [`KBD_FIFO_AW:0]  rd_ptr;
    logic                   empty;
    logic                   full;
    logic                   push;
    logic                   pop;

    // The extra pointer bit separates full from empty.
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[`KBD_FIFO_AW-1:0] == rd_ptr[`KBD_FIFO_AW-1:0]) &&
                   (wr_ptr[`KBD_FIFO_AW] != rd_ptr[`KBD_FIFO_AW]);

    assign code_valid = ~empty;
    assign code       = mem[rd_ptr[`KBD_FIFO_AW-1:0]];

    assign pop  = code_valid & code_ready;
    assign push = rx_valid & (~full | pop); // A pop frees the slot on a full FIFO.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (rx_valid && full && !pop) begin
                overflow <= 1'b1; // Sticky until reset.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[`KBD_FIFO_AW-1:0]] <= rx_code;
        end
    end

endmodule

// File: design/status_display.sv
`timescale 1ns/1ps
`include "kbd_defs.svh"

module status_display (
    input  logic                clk,
    input  logic                rst_n,
    input  kbd_pkg::scan_code_t code,
    input  logic                code_valid,
    input  kbd_pkg::scan_code_t rx_code,
    input  logic                rx_valid,
    input  logic                rx_error,
    output kbd_pkg::seg_t       seg0,
    output kbd_pkg::seg_t       seg1,
    output kbd_pkg::seg_t       seg2,
    output kbd_pkg::seg_t       seg3,
    output kbd_pkg::seg_t       seg4,
    output kbd_pkg::seg_t       seg5
);
    import kbd_pkg::*;

    scan_code_t last_code;
    logic       have_last;
    logic [7:0] distinct_bcd; // Tens digit in the upper nibble.
    logic [7:0] error_bcd;

    // Two-digit BCD increment that wraps from 99 to 00.
    function automatic logic [7:0] bcd_inc(input logic [7:0] v);
        logic [3:0] ones;
        logic [3:0] tens;
        ones = v[3:0];
        tens = v[7:4];
        if (ones == 4'd9) begin
            ones = 4'd0;
            tens = (tens == 4'd9) ? 4'd0 : tens + 4'd1;
        end else begin
            ones = ones + 4'd1;
        end
        return {tens, ones};
    endfunction

    // A and B cannot be drawn, so 10 looks like 0 and 11 like 8.
    function automatic seg_t seg_decode(input logic [3:0] d);
        case (d)
            4'd0:  return 7'b0000001;
            4'd1:  return 7'b1001111;
            4'd2:  return 7'b0010010;
            4'd3:  return 7'b0000110;
            4'd4:  return 7'b1001100;
            4'd5:  return 7'b0100100;
            4'd6:  return 7'b1100000;
            4'd7:  return 7'b0001111;
            4'd8:  return 7'b0000000;
            4'd9:  return 7'b0001100;
            4'd10: return 7'b0000001;
            4'd11: return 7'b0000000;
            4'd12: return 7'b0110001;
            4'd13: return 7'b0011100;
            4'd14: return 7'b0110000;
            default: return 7'b0111000;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            have_last    <= 1'b0;
            distinct_bcd <= 8'h00;
            error_bcd    <= 8'h00;
        end else begin
            if (rx_valid) begin
                have_last <= 1'b1;
                if (!have_last || rx_code != last_code) begin
                    distinct_bcd <= bcd_inc(distinct_bcd);
                end
            end
            if (rx_error) begin
                error_bcd <= bcd_inc(error_bcd);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid) begin
            last_code <= rx_code;
        end
    end

    assign seg0 = code_valid ? seg_decode(code[3:0]) : `SEG_BLANK;
    assign seg1 = code_valid ? seg_decode(code[7:4]) : `SEG_BLANK;
    assign seg2 = seg_decode(distinct_bcd[3:0]);
    assign seg3 = seg_decode(distinct_bcd[7:4]);
    assign seg4 = seg_decode(error_bcd[3:0]);
    assign seg5 = seg_decode(error_bcd[7:4]);

endmodule

// File: design/ps2_kbd_top.sv
`timescale 1ns/1ps

module ps2_kbd_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    input  logic                code_ready,
    output kbd_pkg::scan_code_t code,
    output logic                code_valid,
    output logic                overflow,
    output kbd_pkg::seg_t       seg0,
    output kbd_pkg::seg_t       seg1,
    output kbd_pkg::seg_t       seg2,
    output kbd_pkg::seg_t       seg3,
    output kbd_pkg::seg_t       seg4,
    output kbd_pkg::seg_t       seg5
);
    import kbd_pkg::*;

    scan_code_t rx_code;
    logic       rx_valid;
    logic       rx_error;

    ps2_frame_rx rx_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .rx_code  (rx_code),
        .rx_valid (rx_valid),
        .rx_error (rx_error)
    );

    scan_fifo fifo_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_code    (rx_code),
        .rx_valid   (rx_valid),
        .code       (code),
        .code_valid (code_valid),
        .code_ready (code_ready),
        .overflow   (overflow)
    );

    status_display disp_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .code       (code),
        .code_valid (code_valid),
        .rx_code    (rx_code),
        .rx_valid   (rx_valid),
        .rx_error   (rx_error),
        .seg0       (seg0),
        .seg1       (seg1),
        .seg2       (seg2),
        .seg3       (seg3),
        .seg4       (seg4),
        .seg5       (seg5)
    );

endmodule

// File: tb/tb_ps2_kbd.sv
`timescale 1ns/1ps
`include "kbd_defs.svh"

module tb_ps2_kbd;
    import kbd_pkg::*;

    localparam int HALF_PERIOD = 20; // PS/2 half-period in clk cycles.
    localparam int WAIT_LIMIT  = 200;

    logic       clk;
    logic       rst_n;
    logic       ps2_clk;
    logic       ps2_data;
    logic       code_ready;
    scan_code_t code;
    logic       code_valid;
    logic       overflow;
    seg_t       seg0, seg1, seg2, seg3, seg4, seg5;

    scan_code_t exp_q[$];
    scan_code_t stall_code = 8'h00;
    scan_code_t last_code = 8'h00;
    logic       have_last = 1'b0;
    logic       stall_watch = 1'b0;
    int         distinct_cnt = 0;
    int         frame_errs = 0;
    int         fails = 0;
    int         fails_at_start = 0;
    int         checks = 0;
    int         pops = 0;
    int         tests = 0;

    ps2_kbd_top ps2_kbd_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .code_ready (code_ready),
        .code       (code),
        .code_valid (code_valid),
        .overflow   (overflow),
        .seg0       (seg0),
        .seg1       (seg1),
        .seg2       (seg2),
        .seg3       (seg3),
        .seg4       (seg4),
        .seg5       (seg5)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic odd_parity(input scan_code_t c);
        return ~^c;
    endfunction

    // Standard active-low digits. 10 and 11 have no letter form.
    function automatic seg_t seg_ref(input int d);
        case (d)
            0, 10:   return 7'b0000001;
            1:       return 7'b1001111;
            2:       return 7'b0010010;
            3:       return 7'b0000110;
            4:       return 7'b1001100;
            5:       return 7'b0100100;
            6:       return 7'b1100000;
            7:       return 7'b0001111;
            8, 11:   return 7'b0000000;
            9:       return 7'b0001100;
            12:      return 7'b0110001;
            13:      return 7'b0011100;
            14:      return 7'b0110000;
            default: return 7'b0111000;
        endcase
    endfunction

    function automatic int counter_digit(input int cnt, input bit tens);
        return tens ? (cnt % 100) / 10 : cnt % 10;
    endfunction

    task automatic cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            $display("error: %s expected %h got %h", name, exp, got);
            fails++;
        end
    endtask

    // Frame bits go out LSB first, start bit at index 0.
    task automatic send_frame(input scan_code_t c, input bit bad_start, input bit bad_parity,
                              input bit bad_stop, input int nbits);
        logic [10:0] bits;
        int          i;
        bits = {~bad_stop, odd_parity(c) ^ bad_parity, c, bad_start};
        for (i = 0; i < nbits; i++) begin
            ps2_data = bits[i];
            cycles(HALF_PERIOD);
            ps2_clk = 1'b0;
            cycles(HALF_PERIOD);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        cycles(HALF_PERIOD);
    endtask

    task automatic send_good(input scan_code_t c);
        if (exp_q.size() < `KBD_FIFO_DEPTH) begin
            exp_q.push_back(c);
        end
        if (!have_last || c != last_code) begin
            distinct_cnt = (distinct_cnt + 1) % 100;
        end
        have_last = 1'b1;
        last_code = c;
        send_frame(c, 1'b0, 1'b0, 1'b0, 11);
    endtask

    task automatic wait_valid(input logic level);
        int n;
        n = 0;
        while (code_valid !== level && n < WAIT_LIMIT) begin
            cycles(1);
            n++;
        end
        if (code_valid !== level) begin
            $display("timed out waiting for code_valid to become %0d", level);
            fails++;
        end
    endtask

    task automatic check_drained();
        wait_valid(1'b0);
        checks++;
        if (exp_q.size() != 0) begin
            $display("%0d expected codes never came out of the FIFO", exp_q.size());
            fails++;
            exp_q.delete();
        end
    endtask

    task automatic check_counters();
        seg_t e2, e3, e4, e5;
        int   n;
        e2 = seg_ref(counter_digit(distinct_cnt, 1'b0));
        e3 = seg_ref(counter_digit(distinct_cnt, 1'b1));
        e4 = seg_ref(counter_digit(frame_errs, 1'b0));
        e5 = seg_ref(counter_digit(frame_errs, 1'b1));
        n = 0;
        while ({seg2, seg3, seg4, seg5} !== {e2, e3, e4, e5} && n < WAIT_LIMIT) begin
            cycles(1);
            n++;
        end
        check_value("seg2", 8'(seg2), 8'(e2));
        check_value("seg3", 8'(seg3), 8'(e3));
        check_value("seg4", 8'(seg4), 8'(e4));
        check_value("seg5", 8'(seg5), 8'(e5));
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %s, %0d errors", tests, name,
                 (fails == fails_at_start) ? "passed" : "failed", fails - fails_at_start);
        fails_at_start = fails;
    endtask

    // Every pop is checked against the model queue.
    always @(negedge clk) begin
        if (rst_n && code_valid && code_ready) begin
            pops++;
            checks++;
            if (exp_q.size() == 0) begin
                $display("code %h came out of the FIFO while no code was expected", code);
                fails++;
            end else begin
                if (code !== exp_q[0]) begin
                    $display("error: code expected %h got %h", exp_q[0], code);
                    fails++;
                end
                void'(exp_q.pop_front());
            end
        end
        if (stall_watch && (code !== stall_code || code_valid !== 1'b1)) begin
            $display("error: code expected %h got %h, code_valid %h", stall_code, code, code_valid);
            fails++;
        end
    end

    initial begin
        int         i;
        int         pops_before;
        scan_code_t first;
        scan_code_t disp_seq [9];
        void'($urandom(44));
        rst_n      = 1'b0;
        ps2_clk    = 1'b1;
        ps2_data   = 1'b1;
        code_ready = 1'b0;
        cycles(16);
        rst_n = 1'b1;
        cycles(2);
        check_value("code_valid", 8'(code_valid), 8'h00);
        check_value("overflow", 8'(overflow), 8'h00);
        check_value("seg0", 8'(seg0), 8'(`SEG_BLANK));
        check_value("seg1", 8'(seg1), 8'(`SEG_BLANK));
        check_counters();
        end_test("reset state");

        code_ready = 1'b1;
        for (i = 0; i < 20; i++) begin
            send_good(scan_code_t'($urandom));
            check_drained();
            check_value("overflow", 8'(overflow), 8'h00);
        end
        end_test("random frames");

        for (i = 0; i < 4; i++) begin
            send_frame(scan_code_t'($urandom), 1'b0, i[0] == 1'b0, i[0] == 1'b1, 11);
            frame_errs = (frame_errs + 1) % 100;
            check_counters();
            check_value("code_valid", 8'(code_valid), 8'h00);
        end
        send_frame(8'hFF, 1'b1, 1'b0, 1'b0, 11); // All ones after it, so no false start.
        check_counters();
        check_value("code_valid", 8'(code_valid), 8'h00);
        end_test("bad frames");

        code_ready = 1'b0;
        first = scan_code_t'($urandom);
        send_good(first);
        wait_valid(1'b1);
        check_value("code", code, first);
        stall_code  = first;
        stall_watch = 1'b1;
        for (i = 1; i < 9; i++) begin
            check_value("overflow", 8'(overflow), 8'h00);
            send_good(scan_code_t'($urandom));
        end
        check_value("overflow", 8'(overflow), 8'h01);
        stall_watch = 1'b0;
        pops_before = pops;
        code_ready  = 1'b1;
        check_drained();
        checks++;
        if (pops - pops_before != `KBD_FIFO_DEPTH) begin
            $display("drained %0d codes instead of %0d", pops - pops_before, `KBD_FIFO_DEPTH);
            fails++;
        end
        end_test("back-pressure");

        disp_seq = '{8'hAB, 8'hAB, 8'h1C, 8'hC5, 8'hC5, 8'hC5, 8'hE3, 8'hAB, 8'hF0};
        for (i = 0; i < 9; i++) begin
            code_ready = 1'b0;
            send_good(disp_seq[i]);
            wait_valid(1'b1);
            check_value("seg0", 8'(seg0), 8'(seg_ref(int'(disp_seq[i][3:0]))));
            check_value("seg1", 8'(seg1), 8'(seg_ref(int'(disp_seq[i][7:4]))));
            code_ready = 1'b1;
            check_drained();
            check_value("seg0", 8'(seg0), 8'(`SEG_BLANK));
            check_value("seg1", 8'(seg1), 8'(`SEG_BLANK));
        end
        check_counters();
        end_test("display");

        send_frame(8'h55, 1'b0, 1'b0, 1'b0, 5);
        cycles(`PS2_FRAME_TIMEOUT + 100);
        frame_errs = (frame_errs + 1) % 100;
        check_counters();
        check_value("code_valid", 8'(code_valid), 8'h00);
        send_good(8'h3A);
        check_drained();
        check_counters();
        end_test("frame timeout");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, fails);
        if (fails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+design
design/kbd_pkg.sv
design/ps2_frame_rx.sv
design/scan_fifo.sv
design/status_display.sv
design/ps2_kbd_top.sv
tb/tb_ps2_kbd.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the PS/2 keyboard testbench with Verilator.

cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_ps2_kbd -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
    exit 0
fi
exit 1
